/* Bender.yml */
package:
  name: snes_cart_loader

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/snes_loader_pkg.sv
      - source/rom_header_detect.sv
      - source/ram_clear.sv
      - source/cheat_code_assembler.sv
      - source/backup_sequencer.sv
      - source/cart_loader_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_cart_loader.sv

/* include/snes_loader_config.svh */
`ifndef SNES_LOADER_CONFIG_SVH
`define SNES_LOADER_CONFIG_SVH

// ================================================
// Widths
// ================================================

// Byte address of the download stream
`define SNES_DL_ADDR_BITS     25
// ROM and RAM address masks
`define SNES_MASK_BITS        24
// Work RAM depth, default clear sweep
`define SNES_WRAM_ADDR_BITS   17
// 512 bytes per backup block
`define SNES_BLOCK_ADDR_BITS  9

// ================================================
// Header locations
// ================================================

`define SNES_COPIER_HDR       'h200
`define SNES_LOROM_INFO       'h7FD6
`define SNES_HIROM_INFO       'hFFD6
`define SNES_EXHIROM_INFO     'h40FFD6

// Size code used when the header gives none
`define SNES_DEFAULT_ROM_SIZE 'hC
// Download index reserved for cheat codes
`define SNES_CODE_INDEX       'hFF

`endif

/* source/backup_sequencer.sv */
`timescale 1ns/1ps
`include "snes_loader_config.svh"

module backup_sequencer (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  logic                              cart_download,
	input  logic [`SNES_MASK_BITS-1:0]        ram_mask,
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic [63:0]                       img_size,
	input  logic                              bk_load_req,
	input  logic                              bk_save_req,
	input  logic                              autosave,
	input  logic                              osd_open,
	input  logic                              bsram_wr,
	input  logic                              sd_ack,
	output logic [31:0]                       sd_lba,
	output logic                              sd_rd,
	output logic                              sd_wr,
	output logic                              bk_ena,
	output logic                              bk_loading,
	output logic                              bk_pending
);

	localparam int LBA_PAD = 32 - (`SNES_MASK_BITS - `SNES_BLOCK_ADDR_BITS);

	snes_loader_pkg::bk_state_e bk_state;

	logic        dl_prev;
	logic        dl_fall;
	logic        load_go;
	logic        save_go;
	logic        old_load;
	logic        old_save;
	logic        old_ack;
	logic        load_rise;
	logic        save_rise;
	logic        ack_rise;
	logic        ack_fall;
	logic [31:0] last_block;

	// ================================================
	// Enable and pending save
	// ================================================

	assign dl_fall = dl_prev & ~cart_download;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_prev <= 1'b0;
			bk_ena  <= 1'b0;
		end else begin
			dl_prev <= cart_download;
			if (!dl_prev && cart_download)
				bk_ena <= 1'b0;
			// Save image is mounted by the time the download ends
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;
		end
	end

	// Game wrote backup RAM outside the menu
	always_ff @(posedge clk_sys) begin
		if (RESET)
			bk_pending <= 1'b0;
		else if (bk_ena && !osd_open && bsram_wr)
			bk_pending <= 1'b1;
		else if (bk_state == snes_loader_pkg::BK_XFER)
			bk_pending <= 1'b0;
	end

	// ================================================
	// Block transfer FSM
	// ================================================

	assign load_go    = bk_load_req & bk_ena;
	assign save_go    = (bk_save_req | (bk_pending & osd_open & autosave)) & bk_ena;
	assign load_rise  = load_go & ~old_load;
	assign save_rise  = save_go & ~old_save;
	assign ack_rise   = ~old_ack & sd_ack;
	assign ack_fall   = old_ack & ~sd_ack;
	assign last_block = {{LBA_PAD{1'b0}}, ram_mask[`SNES_MASK_BITS-1:`SNES_BLOCK_ADDR_BITS]};

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_state   <= snes_loader_pkg::BK_IDLE;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			old_load <= load_go;
			old_save <= save_go;
			old_ack  <= sd_ack;

			// Host has taken the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (bk_state == snes_loader_pkg::BK_IDLE) begin
				if (load_rise || save_rise || (dl_fall && |img_size && bk_ena)) begin
					// Auto load after download counts as a load
					bk_state   <= snes_loader_pkg::BK_XFER;
					bk_loading <= load_rise || !save_rise;
					sd_lba     <= '0;
					sd_rd      <= load_rise || !save_rise;
					sd_wr      <= !load_rise && save_rise;
				end
			end else if (ack_fall) begin
				if (sd_lba >= last_block) begin
					bk_state   <= snes_loader_pkg::BK_IDLE;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= !bk_loading;
				end
			end
		end
	end

	a_rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_rd && sd_wr));

	// No request outside a transfer
	a_req_in_xfer: assert property (@(posedge clk_sys) disable iff (RESET)
		(sd_rd || sd_wr) |-> bk_state == snes_loader_pkg::BK_XFER);

endmodule

/* source/cart_loader_top.sv */
`timescale 1ns/1ps
`include "snes_loader_config.svh"

module cart_loader_top #(
	parameter int FILL_ADDR_BITS = `SNES_WRAM_ADDR_BITS
) (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  logic                              ioctl_download,
	input  logic [7:0]                        ioctl_index,
	input  logic                              ioctl_wr,
	input  logic [`SNES_DL_ADDR_BITS-1:0]     ioctl_addr,
	input  logic [15:0]                       ioctl_dout,
	input  snes_loader_pkg::header_mode_e     header_mode,
	input  snes_loader_pkg::region_mode_e     region_mode,
	input  snes_loader_pkg::fill_pattern_e    wram_pattern,
	input  logic                              user_reset,
	input  logic                              bk_load_req,
	input  logic                              bk_save_req,
	input  logic                              autosave,
	input  logic                              osd_open,
	input  logic                              img_mounted,
	input  logic                              img_readonly,
	input  logic [63:0]                       img_size,
	input  logic                              sd_ack,
	input  logic                              bsram_wr,
	output logic [7:0]                        rom_type,
	output logic [`SNES_MASK_BITS-1:0]        rom_mask,
	output logic [`SNES_MASK_BITS-1:0]        ram_mask,
	output logic                              pal,
	output logic [FILL_ADDR_BITS-1:0]         fill_addr,
	output logic [7:0]                        fill_data,
	output logic                              fill_we,
	output logic [127:0]                      gg_code,
	output logic                              gg_code_valid,
	output logic                              gg_reset,
	output logic [31:0]                       sd_lba,
	output logic                              sd_rd,
	output logic                              sd_wr,
	output logic                              bk_ena,
	output logic                              led_user,
	output logic                              core_reset_n
);

	logic code_download;
	logic cart_download;
	logic clearing;
	logic bk_loading;
	logic bk_pending;

	// ================================================
	// Download kind and core reset
	// ================================================

	assign code_download = ioctl_download & (ioctl_index == 8'(`SNES_CODE_INDEX));
	assign cart_download = ioctl_download & (ioctl_index != 8'(`SNES_CODE_INDEX));

	always_ff @(posedge clk_sys) begin
		if (RESET)
			core_reset_n <= 1'b0;
		else
			core_reset_n <= !(user_reset || cart_download || bk_loading || clearing);
	end

	assign fill_we  = clearing;
	// Lit while loading or while an autosave is owed
	assign led_user = cart_download | (autosave & bk_pending);

	rom_header_detect u_rom_header_detect (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.header_mode   (header_mode),
		.region_mode   (region_mode),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask),
		.pal           (pal)
	);

	ram_clear #(
		.FILL_ADDR_BITS (FILL_ADDR_BITS)
	) u_ram_clear (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.pattern       (wram_pattern),
		.clearing      (clearing),
		.fill_addr     (fill_addr),
		.fill_data     (fill_data)
	);

	cheat_code_assembler u_cheat_code_assembler (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.code_download (code_download),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.gg_code       (gg_code),
		.gg_code_valid (gg_code_valid),
		.gg_reset      (gg_reset)
	);

	backup_sequencer u_backup_sequencer (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ram_mask      (ram_mask),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.autosave      (autosave),
		.osd_open      (osd_open),
		.bsram_wr      (bsram_wr),
		.sd_ack        (sd_ack),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_ena        (bk_ena),
		.bk_loading    (bk_loading),
		.bk_pending    (bk_pending)
	);

endmodule

/* source/cheat_code_assembler.sv */
`timescale 1ns/1ps
`include "snes_loader_config.svh"

module cheat_code_assembler (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  logic                              code_download,
	input  logic                              cart_download,
	input  logic                              ioctl_wr,
	input  logic [`SNES_DL_ADDR_BITS-1:0]     ioctl_addr,
	input  logic [15:0]                       ioctl_dout,
	output logic [127:0]                      gg_code,
	output logic                              gg_code_valid,
	output logic                              gg_reset
);

	logic code_wr;

	assign code_wr = code_download & ioctl_wr;

	// Record layout is flags, address, compare, replace
	// Each field arrives low word first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  gg_code[111:96]  <= ioctl_dout;
				4'd2:  gg_code[127:112] <= ioctl_dout;
				4'd4:  gg_code[79:64]   <= ioctl_dout;
				4'd6:  gg_code[95:80]   <= ioctl_dout;
				4'd8:  gg_code[47:32]   <= ioctl_dout;
				4'd10: gg_code[63:48]   <= ioctl_dout;
				4'd12: gg_code[15:0]    <= ioctl_dout;
				4'd14: gg_code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last word of a record clocks it into the core
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gg_code_valid <= 1'b0;
			gg_reset      <= 1'b0;
		end else begin
			gg_code_valid <= code_wr && (ioctl_addr[3:0] == 4'd14);
			// New code list or new cartridge drops old codes
			gg_reset      <= (code_wr && ioctl_addr == '0) || cart_download;
		end
	end

endmodule

/* source/ram_clear.sv */
`timescale 1ns/1ps
`include "snes_loader_config.svh"

module ram_clear #(
	parameter int FILL_ADDR_BITS = `SNES_WRAM_ADDR_BITS
) (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  logic                              cart_download,
	input  snes_loader_pkg::fill_pattern_e    pattern,
	output logic                              clearing,
	output logic [FILL_ADDR_BITS-1:0]         fill_addr,
	output logic [7:0]                        fill_data
);

	// Patterns look at bits up to 9
	localparam int PAT_BITS = (FILL_ADDR_BITS > 10) ? FILL_ADDR_BITS : 10;

	logic                dl_prev;
	logic [PAT_BITS-1:0] pat_addr;

	// ================================================
	// Address sweep
	// ================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_prev   <= 1'b0;
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			dl_prev <= cart_download;
			if (clearing && (&fill_addr))
				clearing <= 1'b0;
			else if (!dl_prev && cart_download)
				clearing <= 1'b1;

			if (clearing)
				fill_addr <= fill_addr + 1'b1;
			else
				fill_addr <= '0;
		end
	end

	// Narrow memories see zeros in the upper bits
	assign pat_addr = PAT_BITS'(fill_addr);

	always_comb begin
		case (pattern)
			snes_loader_pkg::FILL_9966: fill_data = (pat_addr[8] ^ pat_addr[2]) ? 8'h66 : 8'h99;
			snes_loader_pkg::FILL_00FF: fill_data = (pat_addr[9] ^ pat_addr[0]) ? 8'hFF : 8'h00;
			snes_loader_pkg::FILL_55:   fill_data = 8'h55;
			default:                    fill_data = 8'hFF;
		endcase
	end

	// Sweep always restarts from the bottom
	a_addr_idle_zero: assert property (@(posedge clk_sys) disable iff (RESET)
		!clearing |-> fill_addr == '0);

endmodule

/* source/rom_header_detect.sv */
`timescale 1ns/1ps
`include "snes_loader_config.svh"

module rom_header_detect (
	input  logic                              clk_sys,
	input  logic                              RESET,
	input  logic                              cart_download,
	input  logic                              ioctl_wr,
	input  logic [`SNES_DL_ADDR_BITS-1:0]     ioctl_addr,
	input  logic [15:0]                       ioctl_dout,
	input  snes_loader_pkg::header_mode_e     header_mode,
	input  snes_loader_pkg::region_mode_e     region_mode,
	output logic [7:0]                        rom_type,
	output logic [`SNES_MASK_BITS-1:0]        rom_mask,
	output logic [`SNES_MASK_BITS-1:0]        ram_mask,
	output logic                              pal
);

	// Info word locations in the stream, past the copier header
	localparam logic [`SNES_DL_ADDR_BITS-1:0] LOROM_INFO_ADDR =
		`SNES_LOROM_INFO + `SNES_COPIER_HDR;
	localparam logic [`SNES_DL_ADDR_BITS-1:0] HIROM_INFO_ADDR =
		`SNES_HIROM_INFO + `SNES_COPIER_HDR;
	localparam logic [`SNES_DL_ADDR_BITS-1:0] EXHIROM_INFO_ADDR =
		`SNES_EXHIROM_INFO + `SNES_COPIER_HDR;

	logic                          hdr_wr;
	logic                          info_valid;
	logic [`SNES_DL_ADDR_BITS-1:0] info_addr;
	logic [`SNES_DL_ADDR_BITS-1:0] ram_info_addr;
	logic [3:0]                    rom_size;
	logic [3:0]                    ram_size;
	logic                          rom_region;

	assign hdr_wr = cart_download & ioctl_wr;

	// Only the forced layouts look at the internal header
	always_comb begin
		info_valid = 1'b1;
		case (header_mode)
			snes_loader_pkg::HDR_LOROM:   info_addr = LOROM_INFO_ADDR;
			snes_loader_pkg::HDR_HIROM:   info_addr = HIROM_INFO_ADDR;
			snes_loader_pkg::HDR_EXHIROM: info_addr = EXHIROM_INFO_ADDR;
			default: begin
				info_valid = 1'b0;
				info_addr  = '0;
			end
		endcase
	end

	// RAM size byte sits one word above
	assign ram_info_addr = info_addr + 2'd2;

	// ================================================
	// Header capture
	// ================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= `SNES_DEFAULT_ROM_SIZE;
			ram_size   <= '0;
			rom_type   <= '0;
			rom_region <= 1'b0;
		end else if (hdr_wr) begin
			if (ioctl_addr == '0) begin
				rom_size <= `SNES_DEFAULT_ROM_SIZE;
				ram_size <= '0;
				// Copier header byte packs both sizes
				if (header_mode == snes_loader_pkg::HDR_AUTO && ioctl_dout[7:0] != 8'h00) begin
					{ram_size, rom_size} <= ioctl_dout[7:0];
				end
				case (header_mode)
					snes_loader_pkg::HDR_NONE:    rom_type <= 8'd0;
					snes_loader_pkg::HDR_LOROM:   rom_type <= 8'd0;
					snes_loader_pkg::HDR_HIROM:   rom_type <= 8'd1;
					snes_loader_pkg::HDR_EXHIROM: rom_type <= 8'd2;
					default:                      rom_type <= ioctl_dout[15:8];
				endcase
			end
			if (ioctl_addr == `SNES_DL_ADDR_BITS'(2)) begin
				rom_region <= ioctl_dout[8];
			end
			if (info_valid && ioctl_addr == info_addr) begin
				rom_size <= ioctl_dout[11:8];
			end
			if (info_valid && ioctl_addr == ram_info_addr) begin
				ram_size <= ioctl_dout[3:0];
			end
		end
	end

	assign rom_mask = (`SNES_MASK_BITS'(1024) << rom_size) - 1'b1;
	assign ram_mask = (ram_size != 4'd0) ? (`SNES_MASK_BITS'(1024) << ram_size) - 1'b1 : '0;

	// Region is held steady while a cartridge streams in
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			pal <= 1'b0;
		end else if (!cart_download) begin
			if (region_mode == snes_loader_pkg::REGION_AUTO)
				pal <= rom_region;
			else
				pal <= (region_mode == snes_loader_pkg::REGION_PAL);
		end
	end

endmodule

/* source/snes_loader_pkg.sv */
package snes_loader_pkg;

	// ================================================
	// Menu selections
	// ================================================

	// ROM header handling, auto uses the copier header byte
	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_e;

	// Video region override
	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} region_mode_e;

	// Power-on work RAM contents
	typedef enum logic [1:0] {
		FILL_9966 = 2'd0,
		FILL_00FF = 2'd1,
		FILL_55   = 2'd2,
		FILL_FF   = 2'd3
	} fill_pattern_e;

	// ================================================
	// Backup RAM transfer FSM
	// ================================================

	typedef enum logic {
		BK_IDLE = 1'b0,
		BK_XFER = 1'b1
	} bk_state_e;

endpackage

/* verification/tb_cart_loader.sv */
`timescale 1ns/1ps
`include "snes_loader_config.svh"

module tb_cart_loader;

	localparam int FILL_BITS    = 10;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_ROWS     = 6;
	// One cart download with its whole clear sweep
	localparam int ROW_CYCLES   = (1 << FILL_BITS) + 400;
	// Ack delay of up to 10 cycles plus the handshake
	localparam int BLOCK_CYCLES = 20;
	localparam int MAX_BLOCKS   = 16;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + (NUM_ROWS + 1) * ROW_CYCLES
		+ 3 * MAX_BLOCKS * BLOCK_CYCLES);

	typedef struct packed {
		snes_loader_pkg::header_mode_e  mode;
		snes_loader_pkg::region_mode_e  region;
		snes_loader_pkg::fill_pattern_e pattern;
		logic [15:0]                    word0;
		logic [15:0]                    word2;
		logic                           info_en;
		logic [15:0]                    info_word;
		logic [15:0]                    ram_word;
		logic [7:0]                     exp_type;
		logic [`SNES_MASK_BITS-1:0]     exp_rom_mask;
		logic [`SNES_MASK_BITS-1:0]     exp_ram_mask;
		logic                           exp_pal;
	} hdr_row_t;

	logic                               clk_sys;
	logic                               RESET;
	logic                               ioctl_download;
	logic [7:0]                         ioctl_index;
	logic                               ioctl_wr;
	logic [`SNES_DL_ADDR_BITS-1:0]      ioctl_addr;
	logic [15:0]                        ioctl_dout;
	snes_loader_pkg::header_mode_e      header_mode;
	snes_loader_pkg::region_mode_e      region_mode;
	snes_loader_pkg::fill_pattern_e     wram_pattern;
	logic                               user_reset;
	logic                               bk_load_req;
	logic                               bk_save_req;
	logic                               autosave;
	logic                               osd_open;
	logic                               img_mounted;
	logic                               img_readonly;
	logic [63:0]                        img_size;
	logic                               sd_ack;
	logic                               bsram_wr;
	logic [7:0]                         rom_type;
	logic [`SNES_MASK_BITS-1:0]         rom_mask;
	logic [`SNES_MASK_BITS-1:0]         ram_mask;
	logic                               pal;
	logic [FILL_BITS-1:0]               fill_addr;
	logic [7:0]                         fill_data;
	logic                               fill_we;
	logic [127:0]                       gg_code;
	logic                               gg_code_valid;
	logic                               gg_reset;
	logic [31:0]                        sd_lba;
	logic                               sd_rd;
	logic                               sd_wr;
	logic                               bk_ena;
	logic                               led_user;
	logic                               core_reset_n;

	hdr_row_t    rows [NUM_ROWS];
	hdr_row_t    load_row;
	logic [15:0] code_words [8];

	int          err_count;
	int          tests_run;
	int          tests_failed;
	int          fill_cycles;
	int          valid_pulses;
	int          reset_cycles;
	int          blocks_done;
	int          ack_delay;
	int          watchdog_cycles;
	int          errs;
	int          exp_blocks;
	logic        prev_fill_we;
	logic [31:0] lcg_state;
	logic [31:0] lba_log [$];
	logic        kind_log [$];

	cart_loader_top #(
		.FILL_ADDR_BITS (FILL_BITS)
	) u_dut (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.header_mode    (header_mode),
		.region_mode    (region_mode),
		.wram_pattern   (wram_pattern),
		.user_reset     (user_reset),
		.bk_load_req    (bk_load_req),
		.bk_save_req    (bk_save_req),
		.autosave       (autosave),
		.osd_open       (osd_open),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.img_size       (img_size),
		.sd_ack         (sd_ack),
		.bsram_wr       (bsram_wr),
		.rom_type       (rom_type),
		.rom_mask       (rom_mask),
		.ram_mask       (ram_mask),
		.pal            (pal),
		.fill_addr      (fill_addr),
		.fill_data      (fill_data),
		.fill_we        (fill_we),
		.gg_code        (gg_code),
		.gg_code_valid  (gg_code_valid),
		.gg_reset       (gg_reset),
		.sd_lba         (sd_lba),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.bk_ena         (bk_ena),
		.led_user       (led_user),
		.core_reset_n   (core_reset_n)
	);

	always #10 clk_sys = ~clk_sys;

	// ================================================
	// Helpers
	// ================================================

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:16];
	endfunction

	// Power-on fill rule, indexed by the sweep position
	function automatic logic [7:0] fill_expect(input snes_loader_pkg::fill_pattern_e pat,
			input logic [9:0] addr);
		case (pat)
			snes_loader_pkg::FILL_9966: return (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			snes_loader_pkg::FILL_00FF: return (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			snes_loader_pkg::FILL_55:   return 8'h55;
			default:                    return 8'hFF;
		endcase
	endfunction

	// Internal header address in the stream, copier header included
	function automatic logic [`SNES_DL_ADDR_BITS-1:0] info_location(
			input snes_loader_pkg::header_mode_e mode);
		case (mode)
			snes_loader_pkg::HDR_LOROM:   return `SNES_LOROM_INFO + `SNES_COPIER_HDR;
			snes_loader_pkg::HDR_HIROM:   return `SNES_HIROM_INFO + `SNES_COPIER_HDR;
			snes_loader_pkg::HDR_EXHIROM: return `SNES_EXHIROM_INFO + `SNES_COPIER_HDR;
			default:                      return '0;
		endcase
	endfunction

	task automatic compare_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			err_count++;
			$display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (err_count != errs_before) begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, err_count - errs_before);
		end else begin
			$display("Test %s: passed", name);
		end
	endtask

	// Called right after a rising edge, away from the monitor
	task automatic clear_counts();
		fill_cycles  = 0;
		valid_pulses = 0;
		reset_cycles = 0;
		blocks_done  = 0;
		lba_log.delete();
		kind_log.delete();
	endtask

	task automatic write_word(input logic [`SNES_DL_ADDR_BITS-1:0] addr,
			input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;
	endtask

	task automatic download_cart(input hdr_row_t row);
		@(posedge clk_sys);
		ioctl_index    <= 8'h00;
		header_mode    <= row.mode;
		region_mode    <= row.region;
		wram_pattern   <= row.pattern;
		ioctl_download <= 1'b1;
		write_word('0, row.word0);
		write_word(`SNES_DL_ADDR_BITS'(2), row.word2);
		if (row.info_en) begin
			write_word(info_location(row.mode), row.info_word);
			write_word(info_location(row.mode) + 2'd2, row.ram_word);
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
	endtask

	task automatic wait_clear_done();
		@(negedge clk_sys);
		while (fill_we)
			@(negedge clk_sys);
		@(posedge clk_sys);
	endtask

	task automatic check_blocks(input int count, input logic is_save);
		compare_value("block count", lba_log.size(), count);
		for (int i = 0; i < lba_log.size(); i++) begin
			compare_value("sd_lba", lba_log[i], i);
			compare_value("sd_wr", kind_log[i], is_save);
		end
	endtask

	task automatic fill_table();
		rows[0] = '{snes_loader_pkg::HDR_AUTO, snes_loader_pkg::REGION_AUTO,
			snes_loader_pkg::FILL_9966, 16'h0321, 16'h0100, 1'b0, 16'h0, 16'h0,
			8'h03, 24'h0007FF, 24'h000FFF, 1'b1};
		rows[1] = '{snes_loader_pkg::HDR_AUTO, snes_loader_pkg::REGION_NTSC,
			snes_loader_pkg::FILL_00FF, 16'h0500, 16'h0100, 1'b0, 16'h0, 16'h0,
			8'h05, 24'h3FFFFF, 24'h000000, 1'b0};
		rows[2] = '{snes_loader_pkg::HDR_NONE, snes_loader_pkg::REGION_PAL,
			snes_loader_pkg::FILL_55, 16'h7F33, 16'h0000, 1'b0, 16'h0, 16'h0,
			8'h00, 24'h3FFFFF, 24'h000000, 1'b1};
		rows[3] = '{snes_loader_pkg::HDR_LOROM, snes_loader_pkg::REGION_AUTO,
			snes_loader_pkg::FILL_FF, 16'h0000, 16'h0000, 1'b1, 16'h0A00, 16'h0003,
			8'h00, 24'h0FFFFF, 24'h001FFF, 1'b0};
		rows[4] = '{snes_loader_pkg::HDR_HIROM, snes_loader_pkg::REGION_AUTO,
			snes_loader_pkg::FILL_9966, 16'h00FF, 16'h0100, 1'b1, 16'h0B00, 16'h0001,
			8'h01, 24'h1FFFFF, 24'h0007FF, 1'b1};
		rows[5] = '{snes_loader_pkg::HDR_EXHIROM, snes_loader_pkg::REGION_NTSC,
			snes_loader_pkg::FILL_00FF, 16'hFFFF, 16'h0100, 1'b1, 16'h0D00, 16'h0005,
			8'h02, 24'h7FFFFF, 24'h007FFF, 1'b0};
		// Copier byte 0x10 gives 2 KB of backup RAM, four blocks
		load_row = '{snes_loader_pkg::HDR_AUTO, snes_loader_pkg::REGION_AUTO,
			snes_loader_pkg::FILL_55, 16'h0010, 16'h0000, 1'b0, 16'h0, 16'h0,
			8'h00, 24'h0003FF, 24'h0007FF, 1'b0};
		code_words = '{16'h0001, 16'h8000, 16'h1234, 16'h007E,
			16'h00AA, 16'h0000, 16'h00BB, 16'h0000};
	endtask

	// ================================================
	// SD host model and output monitor
	// ================================================

	always begin
		@(posedge clk_sys);
		if (!RESET && (sd_rd || sd_wr)) begin
			lba_log.push_back(sd_lba);
			kind_log.push_back(sd_wr);
			ack_delay = 3 + lcg_next() % 8;
			repeat (ack_delay) @(posedge clk_sys);
			sd_ack <= 1'b1;
			repeat (2) @(posedge clk_sys);
			sd_ack <= 1'b0;
			blocks_done++;
			@(posedge clk_sys);
		end
	end

	always @(negedge clk_sys) begin
		if (!RESET) begin
			// Core stays in reset one cycle behind the clear
			if (prev_fill_we)
				compare_value("core_reset_n", core_reset_n, 1'b0);
			if (fill_we) begin
				compare_value("fill_addr", fill_addr, fill_cycles[FILL_BITS-1:0]);
				compare_value("fill_data", fill_data,
					fill_expect(wram_pattern, fill_cycles[9:0]));
				fill_cycles++;
			end
			if (gg_code_valid)
				valid_pulses++;
			if (gg_reset)
				reset_cycles++;
			prev_fill_we = fill_we;
		end
	end

	initial begin
		watchdog_cycles = 0;
		while (watchdog_cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			watchdog_cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	// ================================================
	// Test sequence
	// ================================================

	initial begin
		clk_sys        = 1'b0;
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = 16'h0000;
		header_mode    = snes_loader_pkg::HDR_AUTO;
		region_mode    = snes_loader_pkg::REGION_AUTO;
		wram_pattern   = snes_loader_pkg::FILL_9966;
		user_reset     = 1'b0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		autosave       = 1'b0;
		osd_open       = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = 64'd0;
		sd_ack         = 1'b0;
		bsram_wr       = 1'b0;
		err_count      = 0;
		tests_run      = 0;
		tests_failed   = 0;
		prev_fill_we   = 1'b0;
		lcg_state      = 32'd37;
		clear_counts();
		fill_table();

		// Outputs settle low under reset, core leaves reset once idle
		errs = err_count;
		repeat (RESET_CYCLES - 1) @(posedge clk_sys);
		@(negedge clk_sys);
		compare_value("sd_rd", sd_rd, 1'b0);
		compare_value("sd_wr", sd_wr, 1'b0);
		compare_value("fill_we", fill_we, 1'b0);
		compare_value("gg_code_valid", gg_code_valid, 1'b0);
		compare_value("gg_reset", gg_reset, 1'b0);
		compare_value("bk_ena", bk_ena, 1'b0);
		compare_value("led_user", led_user, 1'b0);
		compare_value("core_reset_n", core_reset_n, 1'b0);
		@(posedge clk_sys);
		RESET <= 1'b0;
		repeat (2) @(negedge clk_sys);
		compare_value("core_reset_n", core_reset_n, 1'b1);
		report_test("reset_values", errs);

		// Eight words make one record
		errs = err_count;
		@(posedge clk_sys);
		clear_counts();
		ioctl_index    <= 8'(`SNES_CODE_INDEX);
		ioctl_download <= 1'b1;
		for (int i = 0; i < 8; i++)
			write_word(`SNES_DL_ADDR_BITS'(2 * i), code_words[i]);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sys);
		compare_value("gg_code_valid pulses", valid_pulses, 1);
		compare_value("gg_reset seen", reset_cycles != 0, 1'b1);
		compare_value("gg_code", gg_code, {code_words[1], code_words[0], code_words[3],
			code_words[2], code_words[5], code_words[4], code_words[7], code_words[6]});
		report_test("cheat_code", errs);

		for (int r = 0; r < NUM_ROWS; r++) begin
			errs = err_count;
			@(posedge clk_sys);
			clear_counts();
			download_cart(rows[r]);
			wait_clear_done();
			compare_value("fill_we cycles", fill_cycles, 1 << FILL_BITS);
			compare_value("gg_reset seen", reset_cycles != 0, 1'b1);
			compare_value("rom_type", rom_type, rows[r].exp_type);
			compare_value("rom_mask", rom_mask, rows[r].exp_rom_mask);
			compare_value("ram_mask", ram_mask, rows[r].exp_ram_mask);
			compare_value("pal", pal, rows[r].exp_pal);
			report_test($sformatf("header_row_%0d", r), errs);
		end

		// Writable image, load follows the download
		errs = err_count;
		exp_blocks = int'(load_row.exp_ram_mask[`SNES_MASK_BITS-1:`SNES_BLOCK_ADDR_BITS]) + 1;
		@(posedge clk_sys);
		img_mounted  <= 1'b1;
		img_readonly <= 1'b0;
		img_size     <= 64'h800;
		autosave     <= 1'b1;
		clear_counts();
		download_cart(load_row);
		@(negedge clk_sys);
		while (!core_reset_n)
			@(negedge clk_sys);
		compare_value("blocks done at core start", blocks_done, exp_blocks);
		repeat (6) @(negedge clk_sys);
		check_blocks(exp_blocks, 1'b0);
		compare_value("ram_mask", ram_mask, load_row.exp_ram_mask);
		compare_value("bk_ena", bk_ena, 1'b1);

		// Requested reload with no clear running, only the load holds the core
		@(posedge clk_sys);
		clear_counts();
		bk_load_req <= 1'b1;
		@(negedge clk_sys);
		while (blocks_done < exp_blocks)
			@(negedge clk_sys);
		compare_value("core_reset_n", core_reset_n, 1'b0);
		repeat (2) @(negedge clk_sys);
		compare_value("core_reset_n", core_reset_n, 1'b1);
		check_blocks(exp_blocks, 1'b0);
		@(posedge clk_sys);
		bk_load_req <= 1'b0;
		report_test("backup_load", errs);

		// Game write owes a save, opening the menu runs it
		errs = err_count;
		@(posedge clk_sys);
		clear_counts();
		bsram_wr <= 1'b1;
		@(posedge clk_sys);
		bsram_wr <= 1'b0;
		repeat (2) @(negedge clk_sys);
		compare_value("led_user", led_user, 1'b1);
		@(posedge clk_sys);
		osd_open <= 1'b1;
		@(negedge clk_sys);
		while (blocks_done < exp_blocks)
			@(negedge clk_sys);
		repeat (6) @(negedge clk_sys);
		check_blocks(exp_blocks, 1'b1);
		compare_value("sd_wr", sd_wr, 1'b0);
		compare_value("led_user", led_user, 1'b0);
		@(posedge clk_sys);
		osd_open <= 1'b0;
		report_test("backup_save", errs);

		errs = err_count;
		@(negedge clk_sys);
		compare_value("core_reset_n", core_reset_n, 1'b1);
		@(posedge clk_sys);
		user_reset <= 1'b1;
		repeat (2) @(negedge clk_sys);
		compare_value("core_reset_n", core_reset_n, 1'b0);
		@(posedge clk_sys);
		user_reset <= 1'b0;
		repeat (2) @(negedge clk_sys);
		compare_value("core_reset_n", core_reset_n, 1'b1);
		report_test("user_reset", errs);

		$display("Summary: %0d tests, %0d failed, %0d check errors",
			tests_run, tests_failed, err_count);
		if (err_count == 0 && tests_failed == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
source/snes_loader_pkg.sv
source/rom_header_detect.sv
source/ram_clear.sv
source/cheat_code_assembler.sv
source/backup_sequencer.sv
source/cart_loader_top.sv
verification/tb_cart_loader.sv
